/* all.f */
design/npc_pkg.sv
design/decode_if.sv
design/alu.sv
design/register_file.sv
design/inst_decoder.sv
design/npc.sv
dv/npc_tb.sv

/* design/alu.sv */
`timescale 1ns/100ps

module alu (
    input  npc_pkg::word_t  a,
    input  npc_pkg::word_t  b,
    input  npc_pkg::alu_op_e op,
    output npc_pkg::word_t  result,
    output logic            equal
);
    import npc_pkg::*;

    word_t sum;
    word_t diff;
    logic  lt_signed;
    logic  lt_unsigned;

    assign sum  = a + b;
    assign diff = a - b;

    // compare results are zero-extended to a full word
    assign lt_signed   = ($signed(a) < $signed(b));
    assign lt_unsigned = (a < b);

    always_comb begin
        case (op)
            alu_add:  result = sum;
            alu_sub:  result = diff;
            alu_and:  result = a & b;
            alu_or:   result = a | b;
            alu_xor:  result = a ^ b;
            alu_slt:  result = {{(xlen-1){1'b0}}, lt_signed};
            alu_sltu: result = {{(xlen-1){1'b0}}, lt_unsigned};
            default:  result = '0;
        endcase
    end

    // branch compare, independent of op
    assign equal = (a == b);

endmodule

/* design/decode_if.sv */
`timescale 1ns/100ps

interface decode_if (
    input logic clk,
    input logic reset
);
    import npc_pkg::*;

    reg_idx_t rs1;
    reg_idx_t rs2;
    reg_idx_t rd;
    word_t    imm;
    alu_op_e  alu_op;
    logic     src1_is_pc;
    logic     src2_is_imm;
    logic     reg_wen;
    logic     mem_ren;
    logic     mem_wen;
    logic     byte_access;
    logic     is_branch;
    logic     branch_ne;
    logic     is_jal;
    logic     is_jalr;
    wb_sel_e  wb_sel;
    logic     is_ebreak;

    // clk and reset only reach the decoder for its checks
    modport dec (
        input  clk, reset,
        output rs1, rs2, rd, imm, alu_op, src1_is_pc, src2_is_imm, reg_wen,
        output mem_ren, mem_wen, byte_access, is_branch, branch_ne, is_jal, is_jalr,
        output wb_sel, is_ebreak
    );

    modport dp (
        input rs1, rs2, rd, imm, alu_op, src1_is_pc, src2_is_imm, reg_wen,
        input mem_ren, mem_wen, byte_access, is_branch, branch_ne, is_jal, is_jalr,
        input wb_sel, is_ebreak
    );

endinterface

/* design/inst_decoder.sv */
`timescale 1ns/100ps

module inst_decoder (
    input  npc_pkg::word_t inst,
    decode_if.dec          dec
);
    import npc_pkg::*;

    typedef enum logic [2:0] {fmt_i, fmt_s, fmt_b, fmt_u, fmt_j} imm_fmt_e;

    opcode_e             opcode;
    logic [funct3_w-1:0] funct3;
    logic [funct7_w-1:0] funct7;
    word_t               imm_i;
    word_t               imm_s;
    word_t               imm_b;
    word_t               imm_u;
    word_t               imm_j;
    imm_fmt_e            imm_fmt;
    logic                wen_raw;
    logic                op_known;

    assign opcode  = opcode_e'(inst[opcode_w-1:0]);
    assign funct3  = inst[14:12];
    assign funct7  = inst[31:25];
    assign dec.rs1 = inst[19:15];
    assign dec.rs2 = inst[24:20];
    assign dec.rd  = inst[11:7];

    // all immediates sign-extended from inst[31]
    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_b = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_u = {inst[31:12], 12'b0};
    assign imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

    always_comb begin
        case (imm_fmt)
            fmt_s:   dec.imm = imm_s;
            fmt_b:   dec.imm = imm_b;
            fmt_u:   dec.imm = imm_u;
            fmt_j:   dec.imm = imm_j;
            default: dec.imm = imm_i;
        endcase
    end

    // rd == x0 never writes
    assign dec.reg_wen   = wen_raw && (dec.rd != '0);
    assign dec.is_ebreak = (inst == ebreak_word);

    always_comb begin
        imm_fmt         = fmt_i;
        wen_raw         = 1'b0;
        op_known        = 1'b1;
        dec.alu_op      = alu_add;
        dec.src1_is_pc  = 1'b0;
        dec.src2_is_imm = 1'b0;
        dec.mem_ren     = 1'b0;
        dec.mem_wen     = 1'b0;
        dec.byte_access = 1'b0;
        dec.is_branch   = 1'b0;
        dec.branch_ne   = 1'b0;
        dec.is_jal      = 1'b0;
        dec.is_jalr     = 1'b0;
        dec.wb_sel      = wb_alu;
        case (opcode)
            op_lui: begin
                imm_fmt    = fmt_u;
                wen_raw    = 1'b1;
                dec.wb_sel = wb_imm;
            end
            op_auipc: begin
                imm_fmt         = fmt_u;
                wen_raw         = 1'b1;
                dec.src1_is_pc  = 1'b1;
                dec.src2_is_imm = 1'b1;
            end
            op_jal: begin
                imm_fmt    = fmt_j;
                wen_raw    = 1'b1;
                dec.is_jal = 1'b1;
                dec.wb_sel = wb_pc4;
            end
            op_jalr: begin
                // target comes out of the ALU as rs1 + imm
                dec.src2_is_imm = 1'b1;
                dec.wb_sel      = wb_pc4;
                dec.is_jalr     = (funct3 == 3'b000);
                wen_raw         = (funct3 == 3'b000);
            end
            op_branch: begin
                imm_fmt       = fmt_b;
                dec.alu_op    = alu_sub;
                dec.is_branch = (funct3 == f3_beq) || (funct3 == f3_bne);
                dec.branch_ne = (funct3 == f3_bne);
            end
            op_load: begin
                dec.src2_is_imm = 1'b1;
                dec.wb_sel      = wb_mem;
                dec.byte_access = (funct3 == f3_lbu);
                dec.mem_ren     = (funct3 == f3_lw) || (funct3 == f3_lbu);
                wen_raw         = (funct3 == f3_lw) || (funct3 == f3_lbu);
            end
            op_store: begin
                imm_fmt         = fmt_s;
                dec.src2_is_imm = 1'b1;
                dec.byte_access = (funct3 == f3_sb);
                dec.mem_wen     = (funct3 == f3_sw) || (funct3 == f3_sb);
            end
            op_imm: begin
                dec.src2_is_imm = 1'b1;
                wen_raw         = 1'b1;
                case (funct3)
                    f3_add:  dec.alu_op = alu_add;
                    f3_slt:  dec.alu_op = alu_slt;
                    f3_xor:  dec.alu_op = alu_xor;
                    f3_or:   dec.alu_op = alu_or;
                    f3_and:  dec.alu_op = alu_and;
                    default: wen_raw = 1'b0;
                endcase
            end
            op_reg: begin
                if (funct7 == f7_base) begin
                    wen_raw = 1'b1;
                    case (funct3)
                        f3_add:  dec.alu_op = alu_add;
                        f3_slt:  dec.alu_op = alu_slt;
                        f3_sltu: dec.alu_op = alu_sltu;
                        f3_xor:  dec.alu_op = alu_xor;
                        f3_or:   dec.alu_op = alu_or;
                        f3_and:  dec.alu_op = alu_and;
                        default: wen_raw = 1'b0;
                    endcase
                end else if (funct7 == f7_sub && funct3 == f3_add) begin
                    wen_raw    = 1'b1;
                    dec.alu_op = alu_sub;
                end
            end
            // only ebreak is acted on, the rest of system space is a no-op
            op_system: op_known = 1'b1;
            default:   op_known = 1'b0;
        endcase
    end

    // fetch should never land on data or unsupported code
    a_known_opcode: assert property (@(posedge dec.clk) disable iff (dec.reset) op_known)
        else $error("unsupported opcode %07b in inst %08h", inst[6:0], inst);

endmodule

/* design/npc.sv */
`timescale 1ns/100ps

module npc (
    input  logic              clk,
    input  logic              reset,
    input  npc_pkg::word_t    inst,
    input  npc_pkg::word_t    mem_rdata,
    output npc_pkg::word_t    pc,
    output npc_pkg::word_t    mem_addr,
    output npc_pkg::word_t    mem_wdata,
    output logic [3:0]        mem_wmask,
    output logic              mem_ren,
    output logic              mem_wen,
    output logic              rf_wen,
    output npc_pkg::reg_idx_t rf_waddr,
    output npc_pkg::word_t    rf_wdata,
    output logic              halted
);
    import npc_pkg::*;

    word_t      rs1_data;
    word_t      rs2_data;
    word_t      alu_a;
    word_t      alu_b;
    word_t      alu_result;
    logic       alu_equal;
    word_t      pc_plus4;
    word_t      pc_target;
    word_t      next_pc;
    logic       branch_taken;
    logic [1:0] byte_lane;
    word_t      load_data;
    logic       core_active;

    decode_if dec_bus (.clk(clk), .reset(reset));

    inst_decoder i_decoder (
        .inst (inst),
        .dec  (dec_bus.dec)
    );

    register_file i_regfile (
        .clk    (clk),
        .raddr1 (dec_bus.rs1),
        .raddr2 (dec_bus.rs2),
        .wen    (rf_wen),
        .waddr  (rf_waddr),
        .wdata  (rf_wdata),
        .rdata1 (rs1_data),
        .rdata2 (rs2_data)
    );

    // operand muxes
    assign alu_a = dec_bus.src1_is_pc ? pc : rs1_data;
    assign alu_b = dec_bus.src2_is_imm ? dec_bus.imm : rs2_data;

    alu i_alu (
        .a      (alu_a),
        .b      (alu_b),
        .op     (dec_bus.alu_op),
        .result (alu_result),
        .equal  (alu_equal)
    );

    // next pc
    assign pc_plus4     = pc + 32'd4;
    assign pc_target    = pc + dec_bus.imm;
    assign branch_taken = dec_bus.is_branch && (alu_equal ^ dec_bus.branch_ne);

    always_comb begin
        if (dec_bus.is_jalr) begin
            next_pc = {alu_result[31:1], 1'b0};
        end else if (dec_bus.is_jal || branch_taken) begin
            next_pc = pc_target;
        end else begin
            next_pc = pc_plus4;
        end
    end

    // pc freezes on the ebreak word once halted
    always_ff @(posedge clk) begin
        if (reset) begin
            pc     <= reset_pc;
            halted <= 1'b0;
        end else if (!halted) begin
            if (dec_bus.is_ebreak) begin
                halted <= 1'b1;
            end else begin
                pc <= next_pc;
            end
        end
    end

    assign core_active = !reset && !halted;

    // data port, word address with the byte picked by mask and lane
    assign byte_lane = alu_result[1:0];
    assign mem_addr  = {alu_result[31:2], 2'b00};
    assign mem_ren   = dec_bus.mem_ren && !halted;
    assign mem_wen   = dec_bus.mem_wen && core_active;
    assign mem_wmask = dec_bus.byte_access ? (4'b0001 << byte_lane) : 4'b1111;
    assign mem_wdata = dec_bus.byte_access ? {4{rs2_data[7:0]}} : rs2_data;

    // lbu zero-extends the addressed byte
    always_comb begin
        if (dec_bus.byte_access) begin
            case (byte_lane)
                2'd0:    load_data = {24'b0, mem_rdata[7:0]};
                2'd1:    load_data = {24'b0, mem_rdata[15:8]};
                2'd2:    load_data = {24'b0, mem_rdata[23:16]};
                default: load_data = {24'b0, mem_rdata[31:24]};
            endcase
        end else begin
            load_data = mem_rdata;
        end
    end

    // writeback and retire port
    always_comb begin
        case (dec_bus.wb_sel)
            wb_mem:  rf_wdata = load_data;
            wb_pc4:  rf_wdata = pc_plus4;
            wb_imm:  rf_wdata = dec_bus.imm;
            default: rf_wdata = alu_result;
        endcase
    end

    assign rf_wen   = dec_bus.reg_wen && core_active;
    assign rf_waddr = dec_bus.rd;

    // load and store come from one opcode each and must never overlap
    a_mem_exclusive: assert property (@(posedge clk) disable iff (reset) !(mem_wen && mem_ren))
        else $error("mem_ren and mem_wen both high at pc %08h", pc);

    a_pc_aligned: assert property (@(posedge clk) disable iff (reset) pc[1:0] == 2'b00)
        else $error("misaligned pc %08h", pc);

endmodule

/* design/npc_pkg.sv */
package npc_pkg;

    // datapath and decode field widths
    localparam int xlen      = 32;
    localparam int reg_idx_w = 5;
    localparam int opcode_w  = 7;
    localparam int funct3_w  = 3;
    localparam int funct7_w  = 7;

    typedef logic [xlen-1:0]      word_t;
    typedef logic [reg_idx_w-1:0] reg_idx_t;

    // boot address and the only system word the core understands
    localparam word_t reset_pc    = 32'h8000_0000;
    localparam word_t ebreak_word = 32'h0010_0073;

    // major opcodes, inst[6:0]
    typedef enum logic [opcode_w-1:0] {
        op_lui    = 7'b0110111,
        op_auipc  = 7'b0010111,
        op_jal    = 7'b1101111,
        op_jalr   = 7'b1100111,
        op_branch = 7'b1100011,
        op_load   = 7'b0000011,
        op_store  = 7'b0100011,
        op_imm    = 7'b0010011,
        op_reg    = 7'b0110011,
        op_system = 7'b1110011
    } opcode_e;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt,
        alu_sltu
    } alu_op_e;

    // writeback source for rd
    typedef enum logic [1:0] {
        wb_alu,
        wb_mem,
        wb_pc4,
        wb_imm
    } wb_sel_e;

    // funct3 codes of the supported subset
    localparam logic [funct3_w-1:0] f3_add  = 3'b000;
    localparam logic [funct3_w-1:0] f3_slt  = 3'b010;
    localparam logic [funct3_w-1:0] f3_sltu = 3'b011;
    localparam logic [funct3_w-1:0] f3_xor  = 3'b100;
    localparam logic [funct3_w-1:0] f3_or   = 3'b110;
    localparam logic [funct3_w-1:0] f3_and  = 3'b111;
    localparam logic [funct3_w-1:0] f3_beq  = 3'b000;
    localparam logic [funct3_w-1:0] f3_bne  = 3'b001;
    localparam logic [funct3_w-1:0] f3_lw   = 3'b010;
    localparam logic [funct3_w-1:0] f3_lbu  = 3'b100;
    localparam logic [funct3_w-1:0] f3_sb   = 3'b000;
    localparam logic [funct3_w-1:0] f3_sw   = 3'b010;

    localparam logic [funct7_w-1:0] f7_base = 7'b0000000;
    localparam logic [funct7_w-1:0] f7_sub  = 7'b0100000;

endpackage

/* design/register_file.sv */
`timescale 1ns/100ps

module register_file (
    input  logic             clk,
    input  npc_pkg::reg_idx_t raddr1,
    input  npc_pkg::reg_idx_t raddr2,
    input  logic             wen,
    input  npc_pkg::reg_idx_t waddr,
    input  npc_pkg::word_t   wdata,
    output npc_pkg::word_t   rdata1,
    output npc_pkg::word_t   rdata2
);
    import npc_pkg::*;

    // x1..x31, x0 has no storage
    word_t regs [1:31];

    always_ff @(posedge clk) begin
        if (wen && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    // asynchronous reads
    always_comb begin
        if (raddr1 == '0) begin
            rdata1 = '0;
        end else begin
            rdata1 = regs[raddr1];
        end
    end

    always_comb begin
        if (raddr2 == '0) begin
            rdata2 = '0;
        end else begin
            rdata2 = regs[raddr2];
        end
    end

    // decoder is expected to drop writes to x0 before they get here
    a_no_x0_write: assert property (@(posedge clk) wen |-> waddr != '0)
        else $error("register write to x0 with data %08h", wdata);

endmodule

/* dv/npc_patterns.txt */
# I <addr> <inst> | D <addr> <initial word> | M <addr> <final word>   (hex)
# R <reg, decimal> <final value, hex> | H <halt pc, hex> ; text after the values is a note
I 80000000 123450b7 lui x1, 0x12345
I 80000004 00001117 auipc x2, 0x1
I 80000008 06400193 addi x3, x0, 100
I 8000000c ff900213 addi x4, x0, -7
I 80000010 004182b3 add x5, x3, x4
I 80000014 40418333 sub x6, x3, x4
I 80000018 0041f3b3 and x7, x3, x4
I 8000001c 0041e433 or x8, x3, x4
I 80000020 0041c4b3 xor x9, x3, x4
I 80000024 00322533 slt x10, x4, x3
I 80000028 003235b3 sltu x11, x4, x3
I 8000002c fff22613 slti x12, x4, -1
I 80000030 0ff1c693 xori x13, x3, 0xff
I 80000034 7001e713 ori x14, x3, 0x700
I 80000038 0f027793 andi x15, x4, 0xf0
I 8000003c 80001837 lui x16, 0x80001
I 80000040 00182023 sw x1, 0(x16)
I 80000044 003802a3 sb x3, 5(x16)
I 80000048 00082883 lw x17, 0(x16)
I 8000004c 00784903 lbu x18, 7(x16)
I 80000050 00482983 lw x19, 4(x16)
I 80000054 00418463 beq x3, x4, +8 not taken
I 80000058 00419463 bne x3, x4, +8 taken
I 8000005c 00100f93 addi x31, x0, 1 skipped
I 80000060 00188463 beq x17, x1, +8 taken
I 80000064 00200f93 addi x31, x0, 2 skipped
I 80000068 00001463 bne x0, x0, +8 not taken
I 8000006c 00800a6f jal x20, +8
I 80000070 00300f93 addi x31, x0, 3 skipped
I 80000074 00000a97 auipc x21, 0
I 80000078 010a8b67 jalr x22, 16(x21)
I 8000007c 00400f93 addi x31, x0, 4 skipped
I 80000080 00500f93 addi x31, x0, 5 skipped
I 80000084 00982423 sw x9, 8(x16)
I 80000088 00100073 ebreak
D 80001000 deadbeef
D 80001004 aabbccdd
D 80001008 01234567
D 8000100c 55667788
R 0 00000000
R 1 12345000
R 2 80001004
R 3 00000064
R 4 fffffff9
R 5 0000005d
R 6 0000006b
R 7 00000060
R 8 fffffffd
R 9 ffffff9d
R 10 00000001
R 11 00000000
R 12 00000001
R 13 0000009b
R 14 00000764
R 15 000000f0
R 16 80001000
R 17 12345000
R 18 000000aa
R 19 aabb64dd
R 20 80000070
R 21 80000074
R 22 8000007c
R 31 00000000
M 80001000 12345000
M 80001004 aabb64dd
M 80001008 ffffff9d
M 8000100c 55667788
H 80000088

/* dv/npc_tb.sv */
`timescale 1ns/100ps

module npc_tb;
    import npc_pkg::*;

    localparam word_t nop_word     = 32'h0000_0013;
    localparam int    halt_timeout = 2000;
    localparam int    quiet_cycles = 20;

    logic       clk = 1'b0;
    logic       reset;
    word_t      inst;
    word_t      mem_rdata;
    word_t      pc;
    word_t      mem_addr;
    word_t      mem_wdata;
    logic [3:0] mem_wmask;
    logic       mem_ren;
    logic       mem_wen;
    logic       rf_wen;
    reg_idx_t   rf_waddr;
    word_t      rf_wdata;
    logic       halted;

    // sparse memories and expected state from the pattern file
    word_t imem [word_t];
    word_t dmem [word_t];
    word_t mem_expected [word_t];
    word_t reg_expected [32];
    bit    reg_listed [32];
    word_t shadow_regs [32];
    word_t halt_pc;
    bit    halt_listed;
    int    reg_checks;
    int    mem_checks;

    always #4 clk = ~clk;

    npc i_dut (
        .clk       (clk),
        .reset     (reset),
        .inst      (inst),
        .mem_rdata (mem_rdata),
        .pc        (pc),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_wmask (mem_wmask),
        .mem_ren   (mem_ren),
        .mem_wen   (mem_wen),
        .rf_wen    (rf_wen),
        .rf_waddr  (rf_waddr),
        .rf_wdata  (rf_wdata),
        .halted    (halted)
    );

    task automatic stop_on_error(input string reason);
        $display("%s", reason);
        $display("Simulation failed");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_word(input string name, input word_t actual, input word_t expected);
        if (actual !== expected) begin
            $display("[FAIL] %0t ns %s: got %08h, expected %08h", $time, name, actual, expected);
            stop_on_error("word compare mismatch");
        end
    endtask

    task automatic check_reg(input reg_idx_t idx, input word_t actual, input word_t expected);
        if (actual !== expected) begin
            $display("[FAIL] %0t ns x%0d: got %08h, expected %08h", $time, idx, actual, expected);
            stop_on_error("register compare mismatch");
        end
    endtask

    // words never written read back a pattern built from the whole address
    function automatic word_t read_data(input word_t addr);
        if (dmem.exists(addr)) begin
            return dmem[addr];
        end
        return addr ^ 32'h5a5a_5a5a;
    endfunction

    task automatic load_patterns();
        int    fd;
        int    n;
        int    idx;
        string line;
        string fields;
        word_t addr;
        word_t value;
        halt_listed = 1'b0;
        for (int r = 0; r < 32; r++) begin
            reg_listed[r] = 1'b0;
        end
        fd = $fopen("dv/npc_patterns.txt", "r");
        if (fd == 0) begin
            stop_on_error("cannot open the pattern file dv/npc_patterns.txt");
        end
        while (!$feof(fd)) begin
            n = $fgets(line, fd);
            if (n == 0 || line.len() < 3 || line[0] == "#") begin
                continue;
            end
            fields = line.substr(1, line.len() - 1);
            case (line[0])
                "I": begin
                    n = $sscanf(fields, "%h %h", addr, value);
                    imem[addr] = value;
                end
                "D": begin
                    n = $sscanf(fields, "%h %h", addr, value);
                    dmem[addr] = value;
                end
                "M": begin
                    n = $sscanf(fields, "%h %h", addr, value);
                    mem_expected[addr] = value;
                end
                "R": begin
                    n = $sscanf(fields, "%d %h", idx, value);
                    if (idx < 0 || idx > 31) begin
                        stop_on_error({"register index out of range: ", line});
                    end
                    reg_expected[idx] = value;
                    reg_listed[idx]   = 1'b1;
                end
                "H": begin
                    n = $sscanf(fields, "%h", addr) + 1;
                    halt_pc     = addr;
                    halt_listed = 1'b1;
                end
                default: stop_on_error({"unknown record in the pattern file: ", line});
            endcase
            if (n != 2) begin
                stop_on_error({"malformed record in the pattern file: ", line});
            end
        end
        $fclose(fd);
    endtask

    // memory models and retire observer
    initial begin : memory_model
        logic       st_wen;
        word_t      st_addr;
        word_t      st_data;
        logic [3:0] st_mask;
        logic       rt_wen;
        reg_idx_t   rt_addr;
        word_t      rt_data;
        word_t      merged;
        load_patterns();
        for (int r = 0; r < 32; r++) begin
            shadow_regs[r] = '0;
        end
        inst      = nop_word;
        mem_rdata = '0;
        forever begin
            @(negedge clk);
            if (!$isunknown(pc) && imem.exists(pc)) begin
                inst = imem[pc];
            end else begin
                inst = nop_word;
            end
            // read data follows once mem_addr has settled from the new inst
            #2;
            // data port only answers a read strobe
            if (mem_ren) begin
                mem_rdata = read_data(mem_addr);
            end else begin
                mem_rdata = '0;
            end
            #1;
            st_wen = 1'b0;
            rt_wen = 1'b0;
            if (!reset) begin
                if (pc[1:0] != 2'b00) begin
                    stop_on_error($sformatf("fetched pc %08h is not word-aligned", pc));
                end
                if (!imem.exists(pc)) begin
                    stop_on_error($sformatf("fetch from %08h which holds no instruction", pc));
                end
                if (halted && (rf_wen || mem_wen || mem_ren)) begin
                    stop_on_error("a register or memory strobe is high after the halt");
                end
                if (rf_wen && rf_waddr == '0) begin
                    stop_on_error("the retire port writes register x0");
                end
                st_wen  = mem_wen;
                st_addr = mem_addr;
                st_data = mem_wdata;
                st_mask = mem_wmask;
                rt_wen  = rf_wen;
                rt_addr = rf_waddr;
                rt_data = rf_wdata;
            end
            @(posedge clk);
            if (rt_wen) begin
                shadow_regs[rt_addr] = rt_data;
            end
            if (st_wen) begin
                merged = read_data(st_addr);
                for (int b = 0; b < 4; b++) begin
                    if (st_mask[b]) begin
                        merged[8*b +: 8] = st_data[8*b +: 8];
                    end
                end
                dmem[st_addr] = merged;
            end
        end
    end

    initial begin : main_sequence
        int cycles;
        reset      = 1'b1;
        reg_checks = 0;
        mem_checks = 0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        check_word("pc", pc, reset_pc);
        if (rf_wen || mem_wen || halted) begin
            stop_on_error("rf_wen, mem_wen or halted is high while reset is asserted");
        end
        reset = 1'b0;

        cycles = 0;
        while (!halted) begin
            @(negedge clk);
            cycles++;
            if (cycles > halt_timeout) begin
                stop_on_error("the core did not halt within 2000 cycles");
            end
        end
        check_word("pc at halt", pc, halt_pc);
        if (!imem.exists(halt_pc)) begin
            stop_on_error("the halt pc holds no instruction");
        end
        check_word("inst at halt pc", imem[halt_pc], ebreak_word);

        // pc stays frozen and nothing retires after the halt
        for (int i = 0; i < quiet_cycles; i++) begin
            @(negedge clk);
            check_word("pc after halt", pc, halt_pc);
            if (!halted) begin
                stop_on_error("halted dropped without a reset");
            end
        end

        for (int r = 0; r < 32; r++) begin
            if (reg_listed[r]) begin
                check_reg(reg_idx_t'(r), shadow_regs[r], reg_expected[r]);
                reg_checks++;
            end
        end
        foreach (mem_expected[a]) begin
            check_word($sformatf("mem[%08h]", a), read_data(a), mem_expected[a]);
            mem_checks++;
        end

        if (!halt_listed || reg_checks == 0 || mem_checks == 0) begin
            stop_on_error("the pattern file has no H, R or M records to check");
        end else begin
            $display("Simulation completed successfully");
            $finish;
        end
    end

endmodule

/* run_sim.sh */
#!/bin/sh
# build the npc testbench with Verilator and run it from the project root

cd "$(dirname "$0")" || exit 1

log=sim.log
fail_msg="Simulation failed"

verilator --binary --timing --assert -j 0 \
    --top-module npc_tb -Mdir obj_dir -f all.f
if [ $? -ne 0 ]; then
    echo "run_sim: verilator build failed"
    exit 1
fi

./obj_dir/Vnpc_tb > "$log" 2>&1
run_status=$?
cat "$log"

if grep -q "$fail_msg" "$log"; then
    echo "run_sim: FAIL (see $log)"
    exit 1
fi

if [ $run_status -ne 0 ]; then
    echo "run_sim: FAIL, simulator exited with status $run_status"
    exit 1
fi

echo "run_sim: PASS"
exit 0
